/* msx_io_top.f */
+incdir+dv
verilog/msx_io_pkg.sv
verilog/msx_audio_pkg.sv
verilog/io_bus_if.sv
verilog/msx_bus_ctrl.sv
verilog/msx_ppi.sv
verilog/msx_psg.sv
verilog/msx_sound_mix.sv
verilog/msx_io_top.sv
dv/msx_io_tb.sv

/* Bender.yml */
package:
  name: msx_io

sources:
  - verilog/msx_io_pkg.sv
  - verilog/msx_audio_pkg.sv
  - verilog/io_bus_if.sv
  - verilog/msx_bus_ctrl.sv
  - verilog/msx_ppi.sv
  - verilog/msx_psg.sv
  - verilog/msx_sound_mix.sv
  - verilog/msx_io_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/msx_io_tb.sv

/* dv/msx_io_tb_tasks.svh */
`ifndef MSX_IO_TB_TASKS_SVH
`define MSX_IO_TB_TASKS_SVH

// CPU I/O write, wr_n held low for four clocks
task automatic write_port(input logic [15:0] addr, input logic [7:0] data);
   @(posedge clk21m);
   cpu_addr_i   <= addr;
   cpu_data_i   <= data;
   cpu_iorq_n_i <= 1'b0;
   cpu_wr_n_i   <= 1'b0;
   repeat (4) @(posedge clk21m);
   cpu_iorq_n_i <= 1'b1;
   cpu_wr_n_i   <= 1'b1;
endtask

// CPU I/O read, data taken in the middle of the cycle
task automatic read_port(input logic [15:0] addr, output logic [7:0] data);
   @(posedge clk21m);
   cpu_addr_i   <= addr;
   cpu_iorq_n_i <= 1'b0;
   cpu_rd_n_i   <= 1'b0;
   @(negedge clk21m);
   data = cpu_data_o;
   @(posedge clk21m);
   cpu_iorq_n_i <= 1'b1;
   cpu_rd_n_i   <= 1'b1;
endtask

// Register 14 as the CPU sees it, lines active low, pins 1 to 4 reversed
function automatic logic [7:0] joy_model(input logic [7:0] r15, input logic [5:0] j0,
                                          input logic [5:0] j1, input logic cas);
   logic [5:0] j;
   logic       force_hi;
   j        = r15[6] ? j1 : j0;
   force_hi = r15[6] ? r15[5] : r15[4];
   if (force_hi)
      return {cas, 1'b1, 6'h3F};
   else
      return {cas, 1'b1, ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
endfunction

// Expected audio sample as a signed value, twice the mix or clipped
function automatic logic [15:0] audio_model(input logic [3:0] va, input logic [3:0] vb,
                                             input logic [3:0] vc, input logic key,
                                             input logic cas, input logic motor,
                                             input logic [15:0] cart);
   int psg;
   int sum;
   psg = (int'(va) + int'(vb) + int'(vc)) * 16 + (key ? 32 : 0) + ((cas && !motor) ? 16 : 0);
   sum = psg * 16 + int'($signed(cart));
   if (sum >= 16384)
      return 16'h7FFF;
   else if (sum < -16384)
      return 16'h8000;
   else
      return 16'(sum * 2);
endfunction

`endif

/* dv/msx_io_tb.sv */
`timescale 1ns/1ps

module msx_io_tb;

   // Six tests of up to about 400 cycles each, plus margin
   localparam int num_tests  = 6;
   localparam int max_cycles = num_tests * 400 + 1600;

   logic               clk21m;
   logic               exwait_n;
   logic               ce_3m58_i;
   logic [15:0]        cpu_addr_i;
   logic [7:0]         cpu_data_i, kb_data_i, cpu_data_o;
   logic               cpu_iorq_n_i, cpu_mreq_n_i, cpu_rd_n_i, cpu_wr_n_i, cpu_m1_n_i;
   logic [5:0]         joy0_i, joy1_i;
   logic               cas_audio_i, cpu_wait_n_o, cas_motor_o;
   logic signed [15:0] cart_sound_i;
   logic [15:0]        audio_o;
   logic [1:0]         active_slot_o;
   logic [3:0]         kb_row_o;

   integer      seed = 32'hc89e;
   int          err_cnt = 0;
   int          err_start = 0;
   int          pass_cnt = 0;
   int          test_num = 0;
   int          cycle_cnt = 0;
   int          ce_cnt = 0;
   int          n;
   logic [31:0] rnd;
   logic [7:0]  rd, val;
   logic [15:0] cart;
   logic        ce_hit;

   msx_io_top u_dut (.*);

   `include "msx_io_tb_tasks.svh"

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic end_test(input string name);
      test_num++;
      if (err_cnt == err_start) begin
         pass_cnt++;
         $display("test %0d %s: ok", test_num, name);
      end else begin
         $display("test %0d %s: %0d errors", test_num, name, err_cnt - err_start);
      end
      err_start = err_cnt;
   endtask

   initial begin
      clk21m = 1'b0;
      forever #5 clk21m = ~clk21m;
   end

   // ce high for one clock in six
   always @(posedge clk21m) begin
      ce_cnt    <= (ce_cnt == 5) ? 0 : ce_cnt + 1;
      ce_3m58_i <= (ce_cnt == 5);
   end

   always @(posedge clk21m) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("timeout: the run did not end within %0d cycles", max_cycles);
         $display("tests failed");
         $finish;
      end
   end

   // No wait state outside an M1 cycle
   always @(negedge clk21m) begin
      if (exwait_n && cpu_m1_n_i)
         assert (cpu_wait_n_o) else begin
            $display("[ERROR] cpu_wait_n_o: got 0x%h, expected 0x1", cpu_wait_n_o);
            err_cnt++;
         end
   end

   initial begin
      exwait_n     = 1'b0;
      ce_3m58_i    = 1'b0;
      cpu_addr_i   = 16'h0000;
      cpu_data_i   = 8'h00;
      cpu_iorq_n_i = 1'b1;
      cpu_mreq_n_i = 1'b1;
      cpu_rd_n_i   = 1'b1;
      cpu_wr_n_i   = 1'b1;
      cpu_m1_n_i   = 1'b1;
      kb_data_i    = 8'h00;
      joy0_i       = 6'h00;
      joy1_i       = 6'h00;
      cas_audio_i  = 1'b0;
      cart_sound_i = 16'sh0000;
      repeat (8) @(posedge clk21m);
      exwait_n <= 1'b1;

      // Slot 0 until port A is first written, then one field per page
      rnd = $random(seed);
      val = rnd[7:0];
      for (int p = 0; p < 2; p++) begin
         if (p == 1)
            write_port(16'h00A8, val);
         for (int hi = 0; hi < 4; hi++) begin
            @(posedge clk21m);
            cpu_addr_i <= {hi[1:0], 14'h0000};
            @(negedge clk21m);
            check_value("active_slot_o", active_slot_o, (p == 0) ? 2'b00 : val[2*hi +: 2]);
         end
      end
      end_test("reset and slot map");

      rnd = $random(seed);
      val = rnd[7:0];
      write_port(16'h00AA, val);
      @(negedge clk21m);
      check_value("kb_row_o", kb_row_o, val[3:0]);
      check_value("cas_motor_o", cas_motor_o, val[4]);
      read_port(16'h00AA, rd);
      check_value("cpu_data_o", rd, val);
      repeat (4) begin
         rnd = $random(seed);
         write_port(16'h00AB, {4'h0, rnd[3:1], rnd[0]});
         val[rnd[3:1]] = rnd[0];
         read_port(16'h00AA, rd);
         check_value("cpu_data_o", rd, val);
      end
      // Mode word leaves port C alone
      write_port(16'h00AB, {1'b1, rnd[14:8]});
      read_port(16'h00AA, rd);
      check_value("cpu_data_o", rd, val);
      repeat (4) begin
         rnd = $random(seed);
         @(posedge clk21m);
         kb_data_i <= rnd[7:0];
         read_port(16'h00A9, rd);
         check_value("cpu_data_o", rd, rnd[7:0]);
      end
      end_test("ppi port c");

      repeat (8) begin
         rnd = $random(seed);
         write_port(16'h00A0, {4'h0, rnd[3:0] % 4'd14});
         write_port(16'h00A1, rnd[15:8]);
         read_port(16'h00A2, rd);
         check_value("cpu_data_o", rd, rnd[15:8]);
      end
      // Register 15 bits 6 to 4 in every combination
      for (int s = 0; s < 8; s++) begin
         write_port(16'h00A0, 8'd15);
         write_port(16'h00A1, {1'b0, s[2:0], 4'h0});
         write_port(16'h00A0, 8'd14);
         repeat (2) begin
            rnd = $random(seed);
            @(posedge clk21m);
            joy0_i      <= rnd[5:0];
            joy1_i      <= rnd[11:6];
            cas_audio_i <= rnd[12];
            read_port(16'h00A2, rd);
            check_value("cpu_data_o", rd,
                        joy_model({1'b0, s[2:0], 4'h0}, rnd[5:0], rnd[11:6], rnd[12]));
         end
      end
      end_test("psg registers");

      // Last three passes are silent cart and both clip extremes
      for (int i = 0; i < 8; i++) begin
         rnd  = $random(seed);
         cart = (i == 5) ? 16'h0000 : (i == 6) ? 16'h7FFF : (i == 7) ? 16'h8000 : rnd[31:16];
         for (int k = 0; k < 3; k++) begin
            write_port(16'h00A0, 8'd8 + k[7:0]);
            write_port(16'h00A1, rnd[8*k +: 8]);
         end
         write_port(16'h00AB, {4'h0, 3'd7, rnd[24]});
         write_port(16'h00AB, {4'h0, 3'd4, rnd[25]});
         @(posedge clk21m);
         cas_audio_i  <= rnd[26];
         cart_sound_i <= cart;
         @(posedge clk21m);
         @(negedge clk21m);
         check_value("audio_o", audio_o, audio_model(rnd[3:0], rnd[11:8], rnd[19:16],
                                                     rnd[24], rnd[26], rnd[25], cart));
      end
      end_test("audio mix");

      repeat (3) begin
         rnd = $random(seed);
         repeat (7 + rnd[2:0]) @(posedge clk21m);
         cpu_m1_n_i   <= 1'b0;
         cpu_mreq_n_i <= 1'b0;
         n = 0;
         // Low only between the first and second ce edge
         repeat (20) begin
            @(posedge clk21m);
            ce_hit = ce_3m58_i;
            @(negedge clk21m);
            if (ce_hit)
               n++;
            check_value("cpu_wait_n_o", cpu_wait_n_o, n != 1);
         end
         @(posedge clk21m);
         cpu_m1_n_i   <= 1'b1;
         cpu_mreq_n_i <= 1'b1;
      end
      end_test("m1 wait state");

      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         if (i == 0)
            rnd[7:0] = 8'hA3;
         else if (i == 1)
            rnd[7:0] = 8'hAB;
         else
            rnd[6] = 1'b1;
         read_port(rnd[15:0], rd);
         check_value("cpu_data_o", rd, 8'hFF);
      end
      write_port(16'h00AA, 8'h3C);
      @(posedge clk21m);
      cpu_m1_n_i <= 1'b0;
      write_port(16'h00AA, 8'hC3);
      read_port(16'h00A8, rd);
      check_value("cpu_data_o", rd, 8'hFF);
      @(posedge clk21m);
      cpu_m1_n_i <= 1'b1;
      read_port(16'h00AA, rd);
      check_value("cpu_data_o", rd, 8'h3C);
      end_test("unselected ports");

      $display("%0d tests ok, %0d with errors, %0d errors in total",
               pass_cnt, test_num - pass_cnt, err_cnt);
      if (pass_cnt == num_tests && err_cnt == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* verilog/msx_io_top.sv */
`timescale 1ns/1ps

module msx_io_top (
   input  logic               clk21m,
   input  logic               exwait_n,
   input  logic               ce_3m58_i,
   input  logic [15:0]        cpu_addr_i,
   input  logic [7:0]         cpu_data_i,
   input  logic               cpu_iorq_n_i,
   input  logic               cpu_mreq_n_i,
   input  logic               cpu_rd_n_i,
   input  logic               cpu_wr_n_i,
   input  logic               cpu_m1_n_i,
   input  logic [7:0]         kb_data_i,
   input  logic [5:0]         joy0_i,
   input  logic [5:0]         joy1_i,
   input  logic               cas_audio_i,
   input  logic signed [15:0] cart_sound_i,
   output logic [7:0]         cpu_data_o,
   output logic               cpu_wait_n_o,
   output logic [1:0]         active_slot_o,
   output logic [3:0]         kb_row_o,
   output logic               cas_motor_o,
   output logic [15:0]        audio_o
);
   import msx_io_pkg::*;

   logic                   keyclick;
   logic [psg_level_w-1:0] psg_level;

   io_bus_if ppi_bus ();
   io_bus_if psg_bus ();

   msx_bus_ctrl u_bus_ctrl (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .ce_3m58_i    (ce_3m58_i),
      .cpu_addr_i   (cpu_addr_i),
      .cpu_data_i   (cpu_data_i),
      .cpu_iorq_n_i (cpu_iorq_n_i),
      .cpu_mreq_n_i (cpu_mreq_n_i),
      .cpu_rd_n_i   (cpu_rd_n_i),
      .cpu_wr_n_i   (cpu_wr_n_i),
      .cpu_m1_n_i   (cpu_m1_n_i),
      .cpu_data_o   (cpu_data_o),
      .cpu_wait_n_o (cpu_wait_n_o),
      .ppi_bus      (ppi_bus.ctrl),
      .psg_bus      (psg_bus.ctrl)
   );

   msx_ppi u_ppi (
      .clk21m        (clk21m),
      .exwait_n      (exwait_n),
      .cpu_a_hi_i    (cpu_addr_i[15:14]),
      .kb_data_i     (kb_data_i),
      .active_slot_o (active_slot_o),
      .kb_row_o      (kb_row_o),
      .cas_motor_o   (cas_motor_o),
      .keyclick_o    (keyclick),
      .bus           (ppi_bus.periph)
   );

   msx_psg u_psg (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .joy0_i      (joy0_i),
      .joy1_i      (joy1_i),
      .cas_audio_i (cas_audio_i),
      .level_o     (psg_level),
      .bus         (psg_bus.periph)
   );

   msx_sound_mix u_sound_mix (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .level_i      (psg_level),
      .keyclick_i   (keyclick),
      .cas_audio_i  (cas_audio_i),
      .cas_motor_i  (cas_motor_o),
      .cart_sound_i (cart_sound_i),
      .audio_o      (audio_o)
   );

endmodule

/* verilog/msx_sound_mix.sv */
`timescale 1ns/1ps

module msx_sound_mix (
   input  logic                              clk21m,
   input  logic                              exwait_n,
   input  logic [msx_io_pkg::psg_level_w-1:0] level_i,
   input  logic                              keyclick_i,
   input  logic                              cas_audio_i,
   input  logic                              cas_motor_i,
   input  logic signed [15:0]                cart_sound_i,
   output logic [msx_audio_pkg::audio_w-1:0] audio_o
);
   import msx_io_pkg::*;
   import msx_audio_pkg::*;

   logic [psg_level_w-1:0] psg_part;
   logic [mix_w-1:0]       psg_mix;
   logic [mix_w-1:0]       audio_mix;
   logic [audio_w-1:0]     compr;

   // Cassette is only heard while the motor is stopped
   assign psg_part = level_i
                   + (psg_level_w'(keyclick_i) << keyclick_shift)
                   + (psg_level_w'(cas_audio_i & ~cas_motor_i) << cas_shift);

   // PSG side sits four bits up, cartridge sound is sign-extended
   assign psg_mix   = mix_w'(psg_part) << 4;
   assign audio_mix = {cart_sound_i[audio_w-1], cart_sound_i} + psg_mix;

   always_comb begin
      case (audio_mix[mix_w-1 -: 3])
         3'b000:                 compr = {1'b0, audio_mix[13:0], 1'b0};
         3'b111:                 compr = {1'b1, audio_mix[13:0], 1'b0};
         3'b001, 3'b010, 3'b011: compr = sat_pos;
         default:                compr = sat_neg;
      endcase
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n)
         audio_o <= '0;
      else
         audio_o <= compr;
   end

endmodule

/* verilog/msx_psg.sv */
`timescale 1ns/1ps

module msx_psg (
   input  logic                              clk21m,
   input  logic                              exwait_n,
   input  logic [5:0]                        joy0_i,
   input  logic [5:0]                        joy1_i,
   input  logic                              cas_audio_i,
   output logic [msx_io_pkg::psg_level_w-1:0] level_o,
   io_bus_if.periph                          bus
);
   import msx_io_pkg::*;
   import msx_audio_pkg::*;

   logic [3:0] reg_addr_q;
   logic [7:0] regs_q [16];
   logic       wr_en;
   logic [7:0] joy_sel;
   logic [5:0] joy0_map;
   logic [5:0] joy1_map;
   logic [7:0] joy_in;
   logic [5:0] vol_sum;

   assign wr_en = bus.wr_stb & bus.sel;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         reg_addr_q <= 4'h0;
         for (int i = 0; i < 16; i++)
            regs_q[i] <= 8'h00;
      end else if (wr_en) begin
         if (bus.addr == psg_port_addr)
            reg_addr_q <= bus.wdata[3:0];
         else if (bus.addr == psg_port_data)
            regs_q[reg_addr_q] <= bus.wdata;
      end
   end

   assign joy_sel = regs_q[psg_reg_joysel];

   // Lines are active low, pins 1 to 4 come in reversed order
   assign joy0_map = joy_sel[4] ? 6'h3F :
                     {~joy0_i[5], ~joy0_i[4], ~joy0_i[0], ~joy0_i[1], ~joy0_i[2], ~joy0_i[3]};
   assign joy1_map = joy_sel[5] ? 6'h3F :
                     {~joy1_i[5], ~joy1_i[4], ~joy1_i[0], ~joy1_i[1], ~joy1_i[2], ~joy1_i[3]};

   assign joy_in = {cas_audio_i, 1'b1, joy_sel[6] ? joy1_map : joy0_map};

   always_comb begin
      if (bus.addr != psg_port_read)
         bus.rdata = 8'hFF;
      else if (reg_addr_q == psg_reg_joy)
         bus.rdata = joy_in;
      else
         bus.rdata = regs_q[reg_addr_q];
   end

   // Stand-in for the tone mixer, sum of the channel volumes
   assign vol_sum = 6'(regs_q[psg_reg_vol_a][3:0])
                  + 6'(regs_q[psg_reg_vol_a + 4'd1][3:0])
                  + 6'(regs_q[psg_reg_vol_a + 4'd2][3:0]);

   assign level_o = psg_level_w'(vol_sum) << psg_shift;

endmodule

/* verilog/msx_ppi.sv */
`timescale 1ns/1ps

module msx_ppi (
   input  logic       clk21m,
   input  logic       exwait_n,
   input  logic [1:0] cpu_a_hi_i,
   input  logic [7:0] kb_data_i,
   output logic [1:0] active_slot_o,
   output logic [3:0] kb_row_o,
   output logic       cas_motor_o,
   output logic       keyclick_o,
   io_bus_if.periph   bus
);
   import msx_io_pkg::*;

   logic [7:0]     port_a_q;
   logic [7:0]     port_c_q;
   logic           map_valid_q;
   logic           wr_en;
   ppi_ctrl_word_u ctrl_word;

   assign wr_en     = bus.wr_stb & bus.sel;
   assign ctrl_word = bus.wdata;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a_q    <= 8'h00;
         port_c_q    <= 8'h00;
         map_valid_q <= 1'b0;
      end else if (wr_en) begin
         map_valid_q <= 1'b1;
         case (bus.addr)
            ppi_port_a: port_a_q <= bus.wdata;
            ppi_port_c: port_c_q <= bus.wdata;
            ppi_port_ctrl: begin
               // Mode words are ignored, only bit set/reset acts
               if (!ctrl_word.mode_w.flag)
                  port_c_q[ctrl_word.bsr_w.bit_num] <= ctrl_word.bsr_w.bit_val;
            end
            // Port B is input only
            default: ;
         endcase
      end
   end

   always_comb begin
      case (bus.addr)
         ppi_port_a: bus.rdata = port_a_q;
         ppi_port_b: bus.rdata = kb_data_i;
         ppi_port_c: bus.rdata = port_c_q;
         default:    bus.rdata = 8'hFF;
      endcase
   end

   // Two bits of port A per 16K page
   always_comb begin
      if (!map_valid_q)
         active_slot_o = 2'b00;
      else
         active_slot_o = port_a_q[{cpu_a_hi_i, 1'b0} +: 2];
   end

   assign kb_row_o    = port_c_q[3:0];
   assign cas_motor_o = port_c_q[4];
   assign keyclick_o  = port_c_q[7];

endmodule

/* verilog/msx_bus_ctrl.sv */
`timescale 1ns/1ps

module msx_bus_ctrl (
   input  logic        clk21m,
   input  logic        exwait_n,
   input  logic        ce_3m58_i,
   input  logic [15:0] cpu_addr_i,
   input  logic [7:0]  cpu_data_i,
   input  logic        cpu_iorq_n_i,
   input  logic        cpu_mreq_n_i,
   input  logic        cpu_rd_n_i,
   input  logic        cpu_wr_n_i,
   input  logic        cpu_m1_n_i,
   output logic [7:0]  cpu_data_o,
   output logic        cpu_wait_n_o,
   io_bus_if.ctrl      ppi_bus,
   io_bus_if.ctrl      psg_bus
);
   import msx_io_pkg::*;

   logic io_acc;
   logic sel_ppi;
   logic sel_psg;
   logic wr_req;
   logic wr_stb_q;
   logic iack_q;
   logic wait_q;
   logic wait_done_q;

   // I/O cycle outside interrupt acknowledge
   assign io_acc  = ~cpu_iorq_n_i & cpu_m1_n_i;
   assign sel_ppi = io_acc & (cpu_addr_i[7:3] == io_port_ppi[7:3]);
   assign sel_psg = io_acc & (cpu_addr_i[7:3] == io_port_psg[7:3]);

   // One strobe per I/O write, re-armed once the cycle ends
   assign wr_req = io_acc & ~cpu_wr_n_i & ~iack_q;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wr_stb_q <= 1'b0;
         iack_q   <= 1'b0;
      end else begin
         wr_stb_q <= wr_req;
         if (cpu_iorq_n_i & cpu_mreq_n_i)
            iack_q <= 1'b0;
         else if (wr_req)
            iack_q <= 1'b1;
      end
   end

   assign ppi_bus.addr   = cpu_addr_i[1:0];
   assign ppi_bus.wdata  = cpu_data_i;
   assign ppi_bus.wr_stb = wr_stb_q;
   assign ppi_bus.sel    = sel_ppi;

   assign psg_bus.addr   = cpu_addr_i[1:0];
   assign psg_bus.wdata  = cpu_data_i;
   assign psg_bus.wr_stb = wr_stb_q;
   assign psg_bus.sel    = sel_psg;

   // M1 wait, one ce period per opcode fetch
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wait_q      <= 1'b1;
         wait_done_q <= 1'b0;
      end else if (ce_3m58_i) begin
         if (cpu_m1_n_i) begin
            wait_q      <= 1'b1;
            wait_done_q <= 1'b0;
         end else if (!wait_done_q) begin
            wait_q      <= 1'b0;
            wait_done_q <= 1'b1;
         end else begin
            wait_q <= 1'b1;
         end
      end
   end

   // Released as soon as M1 ends, even between ce pulses
   assign cpu_wait_n_o = wait_q | cpu_m1_n_i;

   always_comb begin
      if (cpu_rd_n_i || cpu_iorq_n_i)
         cpu_data_o = 8'hFF;
      else if (sel_ppi)
         cpu_data_o = ppi_bus.rdata;
      else if (sel_psg)
         cpu_data_o = psg_bus.rdata;
      else
         cpu_data_o = 8'hFF;
   end

endmodule

/* verilog/io_bus_if.sv */
`timescale 1ns/1ps

interface io_bus_if;

   // Register offset inside the port group
   logic [1:0] addr;
   logic [7:0] wdata;
   logic       wr_stb;
   logic       sel;
   logic [7:0] rdata;

   modport ctrl (
      output addr,
      output wdata,
      output wr_stb,
      output sel,
      input  rdata
   );

   modport periph (
      input  addr,
      input  wdata,
      input  wr_stb,
      input  sel,
      output rdata
   );

endinterface

/* verilog/msx_audio_pkg.sv */
package msx_audio_pkg;

   // Mix is one bit wider than the output to catch overflow
   localparam int mix_w   = 17;
   localparam int audio_w = 16;

   // Weights of the PSG-side sources
   localparam int keyclick_shift = 5;
   localparam int cas_shift      = 4;
   localparam int psg_shift      = 4;

   // Clip values of the compressor
   localparam logic [15:0] sat_pos = 16'h7FFF;
   localparam logic [15:0] sat_neg = 16'h8000;

endpackage

/* verilog/msx_io_pkg.sv */
package msx_io_pkg;

   // I/O port groups, compared on address bits 7 to 3
   localparam logic [7:0] io_port_psg = 8'hA0;
   localparam logic [7:0] io_port_ppi = 8'hA8;

   // Port offsets inside the PPI group
   localparam logic [1:0] ppi_port_a    = 2'd0;
   localparam logic [1:0] ppi_port_b    = 2'd1;
   localparam logic [1:0] ppi_port_c    = 2'd2;
   localparam logic [1:0] ppi_port_ctrl = 2'd3;

   // Port offsets inside the PSG group
   localparam logic [1:0] psg_port_addr = 2'd0;
   localparam logic [1:0] psg_port_data = 2'd1;
   localparam logic [1:0] psg_port_read = 2'd2;

   // PSG register numbers
   localparam logic [3:0] psg_reg_vol_a  = 4'd8;
   localparam logic [3:0] psg_reg_joy    = 4'd14;
   localparam logic [3:0] psg_reg_joysel = 4'd15;

   // Amplitude level reported by the PSG
   localparam int psg_level_w = 10;

   // PPI control byte, bit 7 picks the view
   typedef union packed {
      struct packed {
         logic       flag;
         logic [6:0] mode;
      } mode_w;
      struct packed {
         logic       flag;
         logic [2:0] unused;
         logic [2:0] bit_num;
         logic       bit_val;
      } bsr_w;
   } ppi_ctrl_word_u;

endpackage
